/* source/slurm16_wb_pkg.sv */
`default_nettype none

package slurm16_wb_pkg;

	// ************************************************************************
	// Instruction fields.
	// ************************************************************************

	localparam int OPCODE_HI = 15;
	localparam int OPCODE_LO = 12;
	localparam int COND_HI   = 11;	// Condition code for cond mov.
	localparam int COND_LO   = 8;
	localparam int DEST3_HI  = 11;	// Three register ALU destination.
	localparam int DEST3_LO  = 8;
	localparam int EXREG_HI  = 10;	// Extended register, r0 to r127.
	localparam int EXREG_LO  = 4;
	localparam int DEST_HI   = 7;
	localparam int DEST_LO   = 4;
	localparam int SRC_HI    = 3;
	localparam int SRC_LO    = 0;
	localparam int MODE_BIT  = 11;	// Store, poke or link.

	// Fixed writeback registers.
	localparam logic [6:0] LINK_REGISTER           = 7'd15;
	localparam logic [6:0] INTERRUPT_LINK_REGISTER = 7'd14;

	// Instruction class from the top nibble.
	typedef enum logic [3:0] {
		OP_NOP                = 4'h0,
		OP_ALU_SINGLE         = 4'h1,
		OP_ALU_REG_REG        = 4'h2,
		OP_ALU_REG_IMM        = 4'h3,
		OP_BRANCH             = 4'h4,
		OP_BYTE_LOAD_STORE    = 4'h5,
		OP_BYTE_LOAD_SX       = 4'h6,
		OP_LOAD_STORE         = 4'h7,
		OP_PEEK_POKE          = 4'h8,
		OP_COND_MOV           = 4'h9,
		OP_THREE_REG_COND_ALU = 4'ha,
		OP_ALU_REG_EXREG      = 4'hb,
		OP_ALU_EXREG_REG      = 4'hc,
		OP_STIX               = 4'hd
	} wb_opcode_t;

	// What the writeback stage stores.
	typedef enum logic [3:0] {
		WB_NONE          = 4'd0,
		WB_ALU           = 4'd1,
		WB_ALU_COND      = 4'd2,	// Gated by the flags in this stage.
		WB_ALU_COND_PASS = 4'd3,	// Gated by the stage 2 result.
		WB_LINK          = 4'd4,
		WB_BYTE_ZX       = 4'd5,
		WB_BYTE_SX       = 4'd6,
		WB_WORD          = 4'd7,
		WB_PORT          = 4'd8,
		WB_CONTEXT       = 4'd9
	} wb_class_t;

	typedef enum logic [3:0] {
		EQ, NE, CS, CC, MI, PL, VS, VC,
		GT, GE, LT, LE, HI, LS, AL, NV
	} cond_code_t;

endpackage

`default_nettype wire

/* source/slurm16_wb_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module slurm16_wb_decode
	import slurm16_wb_pkg::*;
#(
	parameter int REGISTER_BITS = 7,
	parameter int BITS          = 16
) (
	input  logic [BITS-1:0]          instruction,
	input  logic                     is_nop,
	output wb_class_t                wb_class,
	output logic [REGISTER_BITS-1:0] wb_target
);

	wb_opcode_t               opcode;
	logic                     mode;
	logic [REGISTER_BITS-1:0] dest_reg;
	logic [REGISTER_BITS-1:0] src_reg;
	logic [REGISTER_BITS-1:0] dest3_reg;
	logic [REGISTER_BITS-1:0] exreg_reg;

	assign opcode    = wb_opcode_t'(instruction[OPCODE_HI:OPCODE_LO]);
	assign mode      = instruction[MODE_BIT];
	assign dest_reg  = REGISTER_BITS'(instruction[DEST_HI:DEST_LO]);
	assign src_reg   = REGISTER_BITS'(instruction[SRC_HI:SRC_LO]);
	assign dest3_reg = REGISTER_BITS'(instruction[DEST3_HI:DEST3_LO]);
	assign exreg_reg = REGISTER_BITS'(instruction[EXREG_HI:EXREG_LO]);

	// ************************************************************************
	// Class and target selection.
	// ************************************************************************

	always_comb begin
		wb_class  = WB_NONE;
		wb_target = '0;

		if (!is_nop) begin
			case (opcode)
				OP_ALU_SINGLE, OP_ALU_EXREG_REG: begin
					wb_class  = WB_ALU;
					wb_target = src_reg;
				end
				OP_ALU_REG_REG, OP_ALU_REG_IMM: begin
					wb_class  = WB_ALU;
					wb_target = dest_reg;
				end
				OP_ALU_REG_EXREG: begin
					wb_class  = WB_ALU;
					wb_target = exreg_reg;
				end
				OP_BRANCH: begin
					if (mode)
						wb_class = WB_LINK;	// Selector supplies r15.
				end
				OP_BYTE_LOAD_STORE: begin
					if (!mode) begin	// Load.
						wb_class  = WB_BYTE_ZX;
						wb_target = dest_reg;
					end
				end
				OP_BYTE_LOAD_SX: begin
					wb_class  = WB_BYTE_SX;
					wb_target = dest_reg;
				end
				OP_LOAD_STORE: begin
					if (!mode) begin
						wb_class  = WB_WORD;
						wb_target = dest_reg;
					end
				end
				OP_PEEK_POKE: begin
					if (!mode) begin	// Peek.
						wb_class  = WB_PORT;
						wb_target = dest_reg;
					end
				end
				OP_COND_MOV: begin
					wb_class  = WB_ALU_COND;
					wb_target = dest_reg;
				end
				OP_THREE_REG_COND_ALU: begin
					wb_class  = WB_ALU_COND_PASS;
					wb_target = dest3_reg;
				end
				OP_STIX: begin
					wb_class  = WB_CONTEXT;
					wb_target = src_reg;
				end
				default: ;	// NOP and unused opcodes.
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/slurm16_cond_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module slurm16_cond_eval
	import slurm16_wb_pkg::*;
#(
	parameter int BITS = 16
) (
	input  logic [BITS-1:0] instruction,
	input  logic            z,
	input  logic            c,
	input  logic            s,
	input  logic            v,
	output logic            cond_true
);

	cond_code_t cond;

	assign cond = cond_code_t'(instruction[COND_HI:COND_LO]);

	// Flags come from the ALU op just ahead, e.g. a compare.
	always_comb begin
		cond_true = 1'b0;
		case (cond)
			EQ: cond_true = z;
			NE: cond_true = !z;
			CS: cond_true = c;
			CC: cond_true = !c;
			MI: cond_true = s;
			PL: cond_true = !s;
			VS: cond_true = v;
			VC: cond_true = !v;
			GT: cond_true = !z && (s == v);	// Signed greater.
			GE: cond_true = (s == v);
			LT: cond_true = (s != v);
			LE: cond_true = z || (s != v);
			HI: cond_true = !c && !z;	// Unsigned higher.
			LS: cond_true = c || z;
			AL: cond_true = 1'b1;
			NV: cond_true = 1'b0;
			default: cond_true = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/slurm16_wb_select.sv */
`timescale 1ns/1ps
`default_nettype none

module slurm16_wb_select
	import slurm16_wb_pkg::*;
#(
	parameter int REGISTER_BITS = 7,
	parameter int BITS          = 16
) (
	input  wb_class_t                wb_class,
	input  logic [REGISTER_BITS-1:0] wb_target,
	input  logic                     cond_true,
	input  logic                     cond_pass,
	input  logic                     load_interrupt_return_address,
	input  logic [BITS-1:0]          alu_out,
	input  logic [BITS-1:0]          memory_in,
	input  logic [BITS-1:0]          port_in,
	input  logic [BITS-1:0]          pc_stage4,
	input  logic [BITS-1:0]          interrupt_context,
	input  logic [1:0]               memory_wr_mask_delayed,
	output logic [REGISTER_BITS-1:0] reg_wr_sel,
	output logic [BITS-1:0]          reg_out
);

	logic [7:0]      load_byte;
	logic [BITS-1:0] byte_zx;
	logic [BITS-1:0] byte_sx;

	// Byte lane from the delayed write mask; a bad mask loads zero.
	always_comb begin
		case (memory_wr_mask_delayed)
			2'b10:   load_byte = memory_in[15:8];
			2'b01:   load_byte = memory_in[7:0];
			default: load_byte = 8'h00;
		endcase
	end

	assign byte_zx = BITS'(load_byte);
	assign byte_sx = {{(BITS-8){load_byte[7]}}, load_byte};

	// ************************************************************************
	// Register write.
	// ************************************************************************

	always_comb begin
		reg_wr_sel = '0;	// r0 absorbs anything, it reads back as zero.
		reg_out    = '0;

		if (load_interrupt_return_address) begin
			reg_wr_sel = REGISTER_BITS'(INTERRUPT_LINK_REGISTER);
			reg_out    = pc_stage4;
		end else begin
			case (wb_class)
				WB_ALU: begin
					reg_wr_sel = wb_target;
					reg_out    = alu_out;
				end
				WB_ALU_COND: begin
					if (cond_true) begin	// Cond mov.
						reg_wr_sel = wb_target;
						reg_out    = alu_out;
					end
				end
				WB_ALU_COND_PASS: begin
					if (cond_pass) begin
						reg_wr_sel = wb_target;
						reg_out    = alu_out;
					end
				end
				WB_LINK: begin
					reg_wr_sel = REGISTER_BITS'(LINK_REGISTER);
					reg_out    = pc_stage4 + BITS'(2);	// Return past the branch.
				end
				WB_BYTE_ZX: begin
					reg_wr_sel = wb_target;
					reg_out    = byte_zx;
				end
				WB_BYTE_SX: begin
					reg_wr_sel = wb_target;
					reg_out    = byte_sx;
				end
				WB_WORD: begin
					reg_wr_sel = wb_target;
					reg_out    = memory_in;
				end
				WB_PORT: begin
					reg_wr_sel = wb_target;
					reg_out    = port_in;
				end
				WB_CONTEXT: begin
					reg_wr_sel = wb_target;
					reg_out    = interrupt_context;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/slurm16_register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module slurm16_register_file #(
	parameter int REGISTER_BITS = 7,
	parameter int BITS          = 16
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [REGISTER_BITS-1:0] wr_sel,
	input  logic [BITS-1:0]          wr_data,
	input  logic [REGISTER_BITS-1:0] rd_sel_a,
	input  logic [REGISTER_BITS-1:0] rd_sel_b,
	output logic [BITS-1:0]          rd_data_a,
	output logic [BITS-1:0]          rd_data_b
);

	localparam int REG_COUNT = 2 ** REGISTER_BITS;

	logic [BITS-1:0] regs [REG_COUNT];

	// Single write port, r0 never stored.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wr_sel != '0) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// Asynchronous reads.
	assign rd_data_a = (rd_sel_a == '0) ? '0 : regs[rd_sel_a];
	assign rd_data_b = (rd_sel_b == '0) ? '0 : regs[rd_sel_b];

endmodule

`default_nettype wire

/* source/slurm16_writeback_top.sv */
`timescale 1ns/1ps
`default_nettype none

module slurm16_writeback_top
	import slurm16_wb_pkg::*;
#(
	parameter int REGISTER_BITS = 7,
	parameter int BITS          = 16
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [BITS-1:0]          instruction,	// Pipeline slot 4.
	input  logic                     is_nop,
	input  logic [BITS-1:0]          alu_out,
	input  logic [BITS-1:0]          memory_in,
	input  logic [BITS-1:0]          port_in,
	input  logic [BITS-1:0]          pc_stage4,
	input  logic [BITS-1:0]          interrupt_context,
	input  logic [1:0]               memory_wr_mask_delayed,
	input  logic                     load_interrupt_return_address,
	input  logic                     z,
	input  logic                     c,
	input  logic                     s,
	input  logic                     v,
	input  logic                     cond_pass,	// Stage 2 condition result.
	input  logic [REGISTER_BITS-1:0] rd_sel_a,
	input  logic [REGISTER_BITS-1:0] rd_sel_b,
	output logic [REGISTER_BITS-1:0] reg_wr_sel,
	output logic [BITS-1:0]          reg_out,
	output logic [BITS-1:0]          rd_data_a,
	output logic [BITS-1:0]          rd_data_b
);

	wb_class_t                wb_class;
	logic [REGISTER_BITS-1:0] wb_target;
	logic                     cond_true;

	slurm16_wb_decode #(.REGISTER_BITS(REGISTER_BITS), .BITS(BITS)) u_decode (
		.instruction(instruction),
		.is_nop(is_nop),
		.wb_class(wb_class),
		.wb_target(wb_target)
	);

	slurm16_cond_eval #(.BITS(BITS)) u_cond_eval (
		.instruction(instruction),
		.z(z),
		.c(c),
		.s(s),
		.v(v),
		.cond_true(cond_true)
	);

	slurm16_wb_select #(.REGISTER_BITS(REGISTER_BITS), .BITS(BITS)) u_select (
		.wb_class(wb_class),
		.wb_target(wb_target),
		.cond_true(cond_true),
		.cond_pass(cond_pass),
		.load_interrupt_return_address(load_interrupt_return_address),
		.alu_out(alu_out),
		.memory_in(memory_in),
		.port_in(port_in),
		.pc_stage4(pc_stage4),
		.interrupt_context(interrupt_context),
		.memory_wr_mask_delayed(memory_wr_mask_delayed),
		.reg_wr_sel(reg_wr_sel),
		.reg_out(reg_out)
	);

	slurm16_register_file #(.REGISTER_BITS(REGISTER_BITS), .BITS(BITS)) u_register_file (
		.clk(clk),
		.rst(rst),
		.wr_sel(reg_wr_sel),
		.wr_data(reg_out),
		.rd_sel_a(rd_sel_a),
		.rd_sel_b(rd_sel_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b)
	);

endmodule

`default_nettype wire

/* verification/slurm16_writeback_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module slurm16_writeback_chk
	import slurm16_wb_pkg::*;
#(
	parameter int REGISTER_BITS = 7,
	parameter int BITS          = 16
) (
	input logic                     clk,
	input logic                     rst,
	input logic                     load_interrupt_return_address,
	input logic [REGISTER_BITS-1:0] reg_wr_sel,
	input logic [REGISTER_BITS-1:0] rd_sel_a,
	input logic [REGISTER_BITS-1:0] rd_sel_b,
	input logic [BITS-1:0]          rd_data_a,
	input logic [BITS-1:0]          rd_data_b
);

	int failures = 0;	// Read by the testbench at the end of the run.

	// ************************************************************************
	// Writeback port and register file properties.
	// ************************************************************************

	irq_return_target: assert property (@(posedge clk)
		load_interrupt_return_address |->
			reg_wr_sel == REGISTER_BITS'(INTERRUPT_LINK_REGISTER))
		else begin
			failures++;
			$error("Interrupt return address not written to r14.");
		end

	// r0 is hard wired to zero.
	zero_read_a: assert property (@(posedge clk) rd_sel_a == '0 |-> rd_data_a == '0)
		else begin
			failures++;
			$error("Read port A returned nonzero data for r0.");
		end

	zero_read_b: assert property (@(posedge clk) rd_sel_b == '0 |-> rd_data_b == '0)
		else begin
			failures++;
			$error("Read port B returned nonzero data for r0.");
		end

	cleared_after_reset: assert property (@(posedge clk)
		rst |=> (rd_data_a == '0 && rd_data_b == '0))
		else begin
			failures++;
			$error("Register file not cleared after reset.");
		end

endmodule

`default_nettype wire

/* verification/slurm16_writeback_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module slurm16_writeback_tb;

	localparam int REGISTER_BITS = 7;
	localparam int BITS          = 16;
	localparam int PERIOD        = 40;
	localparam int EDGE_LIMIT    = 4 * PERIOD;	// Polling budget per clock edge, in ns.

	// Data words shared by the directed rows.
	localparam logic [15:0] A  = 16'h5a3c;	// ALU result.
	localparam logic [15:0] M  = 16'h9c47;	// Memory word, high byte negative.
	localparam logic [15:0] P  = 16'h0f1e;
	localparam logic [15:0] PC = 16'h0100;
	localparam logic [15:0] X  = 16'h7e11;
	localparam logic        N  = 1'b0;
	localparam logic        Y  = 1'b1;

	typedef struct packed {
		logic [15:0] instr;
		logic        nop;
		logic [15:0] alu;
		logic [15:0] mem;
		logic [15:0] port;
		logic [15:0] pc;
		logic [15:0] ctx;
		logic [1:0]  mask;
		logic [3:0]  flags;	// Z, C, S, V from the top bit down.
		logic        pass;
		logic        irq;
		logic [6:0]  exp_sel;
		logic [15:0] exp_out;
	} row_t;

	logic                     clk;
	logic                     rst;
	logic [BITS-1:0]          instruction;
	logic                     is_nop;
	logic [BITS-1:0]          alu_out;
	logic [BITS-1:0]          memory_in;
	logic [BITS-1:0]          port_in;
	logic [BITS-1:0]          pc_stage4;
	logic [BITS-1:0]          interrupt_context;
	logic [1:0]               memory_wr_mask_delayed;
	logic                     load_interrupt_return_address;
	logic                     z;
	logic                     c;
	logic                     s;
	logic                     v;
	logic                     cond_pass;
	logic [REGISTER_BITS-1:0] rd_sel_a;
	logic [REGISTER_BITS-1:0] rd_sel_b;
	logic [REGISTER_BITS-1:0] reg_wr_sel;
	logic [BITS-1:0]          reg_out;
	logic [BITS-1:0]          rd_data_a;
	logic [BITS-1:0]          rd_data_b;

	row_t        rows[$];
	string       names[$];
	logic [31:0] lcg_state  = 32'd21330;
	int          rise_count = 0;
	int          fall_count = 0;
	int          pass_count = 0;
	int          fail_count = 0;
	logic        timed_out  = 1'b0;
	string       msg;

	// Expected register contents, all zero after reset.
	logic [15:0] stored_regs[2**REGISTER_BITS] = '{default: '0};
	logic [6:0]  last_target = 7'd0;	// Most recent nonzero write target.

	slurm16_writeback_top #(.REGISTER_BITS(REGISTER_BITS), .BITS(BITS)) DUT (.*);

	bind slurm16_writeback_top slurm16_writeback_chk #(
		.REGISTER_BITS(REGISTER_BITS),
		.BITS(BITS)
	) u_chk (
		.clk(clk),
		.rst(rst),
		.load_interrupt_return_address(load_interrupt_return_address),
		.reg_wr_sel(reg_wr_sel),
		.rd_sel_a(rd_sel_a),
		.rd_sel_b(rd_sel_b),
		.rd_data_a(rd_data_a),
		.rd_data_b(rd_data_b)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Edge counters; waits poll these.
	always @(posedge clk) rise_count <= rise_count + 1;
	always @(negedge clk) fall_count <= fall_count + 1;

	// ************************************************************************
	// Reference model and table helpers.
	// ************************************************************************

	function automatic logic cond_holds(input logic [3:0] cc, input logic [3:0] flags);
		logic flag_z;
		logic flag_c;
		logic flag_s;
		logic flag_v;
		{flag_z, flag_c, flag_s, flag_v} = flags;
		case (cc)
			4'h0: return flag_z;
			4'h1: return !flag_z;
			4'h2: return flag_c;
			4'h3: return !flag_c;
			4'h4: return flag_s;
			4'h5: return !flag_s;
			4'h6: return flag_v;
			4'h7: return !flag_v;
			4'h8: return !flag_z && (flag_s == flag_v);	// GT
			4'h9: return flag_s == flag_v;
			4'ha: return flag_s != flag_v;
			4'hb: return flag_z || (flag_s != flag_v);	// LE
			4'hc: return !flag_c && !flag_z;
			4'hd: return flag_c || flag_z;
			4'he: return 1'b1;
			default: return 1'b0;	// NV
		endcase
	endfunction

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	task automatic add_row(input string name, input logic [15:0] instr, input logic nop,
			input logic [15:0] alu, input logic [15:0] mem, input logic [15:0] port,
			input logic [15:0] pc, input logic [15:0] ctx, input logic [1:0] mask,
			input logic [3:0] flags, input logic pass, input logic irq,
			input logic [6:0] exp_sel, input logic [15:0] exp_out);
		names.push_back(name);
		rows.push_back(row_t'({instr, nop, alu, mem, port, pc, ctx, mask, flags, pass, irq,
			exp_sel, exp_out}));
	endtask

	task automatic build_table();
		add_row("alu_single", 16'h1003, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd3, A);
		add_row("alu_reg_reg", 16'h2053, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd5, A);
		add_row("alu_reg_imm", 16'h3070, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd7, A);
		add_row("alu_reg_exreg", 16'hb5a2, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd90, A);
		add_row("alu_exreg_reg", 16'hc7a9, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd9, A);
		add_row("load_word", 16'h7040, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd4, M);
		add_row("store_word", 16'h7840, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd0, 16'h0);
		add_row("byte_zx_hi", 16'h5060, N, A, M, P, PC, X, 2'b10, 4'h0, N, N, 7'd6, 16'h009c);
		add_row("byte_zx_lo", 16'h5060, N, A, M, P, PC, X, 2'b01, 4'h0, N, N, 7'd6, 16'h0047);
		add_row("byte_sx_hi", 16'h6060, N, A, M, P, PC, X, 2'b10, 4'h0, N, N, 7'd6, 16'hff9c);
		add_row("byte_sx_lo", 16'h6060, N, A, 16'h12f0, P, PC, X, 2'b01, 4'h0, N, N, 7'd6,
			16'hfff0);
		add_row("byte_bad_mask", 16'h6060, N, A, M, P, PC, X, 2'b11, 4'h0, N, N, 7'd6, 16'h0);
		add_row("byte_store", 16'h5860, N, A, M, P, PC, X, 2'b10, 4'h0, N, N, 7'd0, 16'h0);
		add_row("peek", 16'h8020, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd2, P);
		add_row("poke", 16'h8820, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd0, 16'h0);
		add_row("branch_link", 16'h4800, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd15, 16'h0102);
		add_row("branch", 16'h4000, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd0, 16'h0);
		add_row("irq_over_load", 16'h7040, N, A, M, P, PC, X, 2'b00, 4'h0, N, Y, 7'd14, PC);
		// HI is false with C set, true with no flags; only cond_pass matters.
		add_row("cond_alu_pass", 16'hac12, N, A, M, P, PC, X, 2'b00, 4'h4, Y, N, 7'd12, A);
		add_row("cond_alu_block", 16'hac12, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd0, 16'h0);
		add_row("stix", 16'hd00b, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd11, X);
		add_row("nop_flag", 16'h2053, Y, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd0, 16'h0);
		add_row("nop_opcode", 16'h0053, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd0, 16'h0);
		add_row("write_r0", 16'h2003, N, A, M, P, PC, X, 2'b00, 4'h0, N, N, 7'd0, A);

		// Cond mov into r8, one true and one false flag set per code.
		for (int cc = 0; cc < 16; cc++) begin
			logic [1:0] seen;
			seen = 2'b00;
			for (int f = 0; f < 16; f++) begin
				logic hold;
				hold = cond_holds(4'(cc), 4'(f));
				if (!seen[hold]) begin
					seen[hold] = 1'b1;
					add_row($sformatf("cmov_cc%0d_%s", cc, hold ? "true" : "false"),
						{4'h9, 4'(cc), 8'h80}, N, A, M, P, PC, X, 2'b00, 4'(f), N, N,
						hold ? 7'd8 : 7'd0, hold ? A : 16'h0000);
				end
			end
		end

		for (int n = 0; n < 20; n++) begin
			logic [15:0] instr;
			logic [15:0] alu;
			instr = next_rand();
			instr[15:12] = 4'h2;	// Register-register ALU.
			alu = next_rand();
			add_row($sformatf("rand_alu_%0d", n), instr, N, alu, M, P, PC, X, 2'b00, 4'h0, N,
				N, {3'b000, instr[7:4]}, alu);
		end
	endtask

	// ************************************************************************
	// Sequencing and checking.
	// ************************************************************************

	// Returns 1 ns after the edge, since the counters update late in the step.
	task automatic wait_edge(input logic rising);
		int start;
		int guard;
		start = rising ? rise_count : fall_count;
		guard = 0;
		while (!timed_out && guard < EDGE_LIMIT &&
				(rising ? rise_count : fall_count) == start) begin
			#1;
			guard++;
		end
		if (guard >= EDGE_LIMIT) begin
			timed_out = 1'b1;
			$display("Timeout: no %s clock edge seen within %0d ns",
				rising ? "rising" : "falling", EDGE_LIMIT);
		end
	endtask

	task automatic drive_row(input row_t r);
		instruction                   = r.instr;
		is_nop                        = r.nop;
		alu_out                       = r.alu;
		memory_in                     = r.mem;
		port_in                       = r.port;
		pc_stage4                     = r.pc;
		interrupt_context             = r.ctx;
		memory_wr_mask_delayed        = r.mask;
		{z, c, s, v}                  = r.flags;
		cond_pass                     = r.pass;
		load_interrupt_return_address = r.irq;
		rd_sel_a                      = r.exp_sel;	// Read back whatever gets written.
		rd_sel_b                      = '0;
	endtask

	task automatic record_result(input string name, input string err);
		if (err == "") begin
			pass_count++;
			$display("PASS %s", name);
		end else begin
			fail_count++;
			$display("%s", err);
		end
	endtask

	task automatic run_row(input string name, input row_t r);
		string       err;
		logic [15:0] exp_read;
		logic [15:0] exp_read_b;
		err = "";
		exp_read = (r.exp_sel == 7'd0) ? 16'h0000 : r.exp_out;
		if (r.exp_sel != 7'd0)
			stored_regs[r.exp_sel] = r.exp_out;
		exp_read_b = stored_regs[last_target];
		wait_edge(1'b0);
		drive_row(r);
		rd_sel_b = last_target;	// An older write must still be held.
		#(PERIOD / 2 - 2);
		if (reg_wr_sel !== r.exp_sel)
			err = $sformatf("ERROR %s reg_wr_sel expected %0d actual %0d",
				name, r.exp_sel, reg_wr_sel);
		else if (reg_out !== r.exp_out)
			err = $sformatf("ERROR %s reg_out expected 0x%04h actual 0x%04h",
				name, r.exp_out, reg_out);
		wait_edge(1'b1);
		if (err == "" && rd_data_a !== exp_read)
			err = $sformatf("ERROR %s rd_data_a expected 0x%04h actual 0x%04h",
				name, exp_read, rd_data_a);
		if (err == "" && rd_data_b !== exp_read_b)
			err = $sformatf("ERROR %s rd_data_b expected 0x%04h actual 0x%04h",
				name, exp_read_b, rd_data_b);
		if (r.exp_sel != 7'd0)
			last_target = r.exp_sel;
		if (!timed_out)
			record_result(name, err);
	endtask

	initial begin
		rst = 1'b1;
		drive_row('0);
		build_table();

		wait_edge(1'b1);
		wait_edge(1'b1);
		wait_edge(1'b0);
		rst      = 1'b0;
		rd_sel_a = 7'd5;
		rd_sel_b = 7'd90;
		#1;
		msg = "";
		if (rd_data_a !== 16'h0000)
			msg = $sformatf("ERROR reset_reads rd_data_a expected 0x0000 actual 0x%04h",
				rd_data_a);
		else if (rd_data_b !== 16'h0000)
			msg = $sformatf("ERROR reset_reads rd_data_b expected 0x0000 actual 0x%04h",
				rd_data_b);
		if (!timed_out)
			record_result("reset_reads", msg);

		for (int i = 0; i < rows.size() && !timed_out; i++)
			run_row(names[i], rows[i]);

		$display("Tests passed %0d failed %0d assertion failures %0d",
			pass_count, fail_count, DUT.u_chk.failures);
		if (!timed_out && fail_count == 0 && DUT.u_chk.failures == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
source/slurm16_wb_pkg.sv
source/slurm16_wb_decode.sv
source/slurm16_cond_eval.sv
source/slurm16_wb_select.sv
source/slurm16_register_file.sv
source/slurm16_writeback_top.sv
verification/slurm16_writeback_chk.sv
verification/slurm16_writeback_tb.sv

/* Makefile */
TOP = slurm16_writeback_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
